// File: design/stream_pkg.sv
`default_nettype none

// stream formats seen on the capture inputs and on the memory word side
package stream_pkg;

  // one input sample as delivered by a channel front end
  localparam int SAMPLE_WIDTH = 48;

  // one word of the shared sample memory
  localparam int WORD_WIDTH = 64;

  // a single sample beat travelling with its end of burst marker
  typedef struct packed {
    logic [SAMPLE_WIDTH-1:0] data;
    logic                    last;
  } sample_beat_t;

  // a memory word beat, used after the converter and on the readout stream
  typedef struct packed {
    logic [WORD_WIDTH-1:0] data;
    logic                  last;
  } word_beat_t;

endpackage

`default_nettype wire

// File: design/memory_pkg.sv
`default_nettype none

// geometry of the shared sample memory and the request format of its one port
package memory_pkg;
  import stream_pkg::*;

  // each capture channel owns one region of the memory
  localparam int CHANNELS = 2;
  localparam int REGION_WORDS = 64;
  localparam int OFFSET_WIDTH = $clog2(REGION_WORDS);
  localparam int MEM_ADDR_WIDTH = $clog2(CHANNELS * REGION_WORDS);

  // writer n sits in slot SLOT_WRITER0 + n and the readout engine takes the slot after them
  localparam int NUM_REQUESTERS = CHANNELS + 1;
  localparam int SLOT_WRITER0 = 0;
  localparam int SLOT_READOUT = CHANNELS;

  typedef logic [$clog2(CHANNELS)-1:0] channel_t;

  // counts run from 0 up to a full region, so one bit wider than an offset
  typedef logic [OFFSET_WIDTH:0] word_count_t;

  // the region bit sits on top, so a region is a contiguous block of words
  typedef struct packed {
    channel_t                region;
    logic [OFFSET_WIDTH-1:0] offset;
  } mem_addr_t;

  // write data is ignored for a read
  typedef struct packed {
    logic                  write;
    mem_addr_t             addr;
    logic [WORD_WIDTH-1:0] wdata;
  } mem_req_t;

endpackage

`default_nettype wire

// File: design/axis_width_converter.sv
`timescale 1ns/1ps
`default_nettype none

// stream width converter made of an upsizer followed by a downsizer
// the input width is first multiplied up to a common multiple of both widths
// and that wide word is then cut into output sized slices
// the upsizer can take a beat every cycle while its output drains, so the input
// rate is bounded by how quickly the downsizer empties its register
// when the downsizer holds several slices the input has to stall now and then
module axis_width_converter #(
  parameter int DWIDTH_IN = 48,
  parameter int DWIDTH_OUT = 64
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [DWIDTH_IN-1:0]  in_data,
  input  logic                  in_last,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [DWIDTH_OUT-1:0] out_data,
  output logic                  out_last,
  output logic                  out_valid,
  input  logic                  out_ready
);

  // euclid's algorithm, evaluated at elaboration time
  function automatic int gcd(input int a, input int b);
    int t;
    while (b != 0) begin
      t = b;
      b = a % b;
      a = t;
    end
    return a;
  endfunction

  localparam int IN_OUT_GCD = gcd(DWIDTH_IN, DWIDTH_OUT);
  localparam int DOWN = DWIDTH_IN / IN_OUT_GCD;
  localparam int UP = DWIDTH_OUT / IN_OUT_GCD;
  localparam int MID_WIDTH = DWIDTH_IN * UP;

  // wide intermediate stream between the two halves
  logic [MID_WIDTH-1:0] mid_data;
  logic                 mid_last;
  logic                 mid_valid;
  logic                 mid_ready;

  generate
    if (UP > 1) begin : g_up
      axis_upsizer #(
        .DWIDTH(DWIDTH_IN),
        .UP(UP)
      ) up_i (
        .clk,
        .reset,
        .in_data,
        .in_last,
        .in_valid,
        .in_ready,
        .out_data(mid_data),
        .out_last(mid_last),
        .out_valid(mid_valid),
        .out_ready(mid_ready)
      );
    end else begin : g_up_reg
      // no packing needed, a single register stage keeps the timing the same shape
      always_ff @(posedge clk) begin
        if (reset) begin
          mid_valid <= 1'b0;
        end else if (in_ready) begin
          mid_valid <= in_valid;
        end
      end
      always_ff @(posedge clk) begin
        if (in_ready) begin
          mid_data <= in_data;
          mid_last <= in_last;
        end
      end
      assign in_ready = mid_ready | ~mid_valid;
    end

    if (DOWN > 1) begin : g_down
      axis_downsizer #(
        .DWIDTH(MID_WIDTH),
        .DOWN(DOWN)
      ) down_i (
        .clk,
        .reset,
        .in_data(mid_data),
        .in_last(mid_last),
        .in_valid(mid_valid),
        .in_ready(mid_ready),
        .out_data,
        .out_last,
        .out_valid,
        .out_ready
      );
    end else begin : g_down_reg
      always_ff @(posedge clk) begin
        if (reset) begin
          out_valid <= 1'b0;
        end else if (mid_ready) begin
          out_valid <= mid_valid;
        end
      end
      always_ff @(posedge clk) begin
        if (mid_ready) begin
          out_data <= mid_data;
          out_last <= mid_last;
        end
      end
      assign mid_ready = out_ready | ~out_valid;
    end
  endgenerate

endmodule

// breaks each wide input beat into DOWN narrower beats, lowest slice first
module axis_downsizer #(
  parameter int DWIDTH = 192,
  parameter int DOWN = 3
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic [DWIDTH-1:0]        in_data,
  input  logic                     in_last,
  input  logic                     in_valid,
  output logic                     in_ready,
  output logic [DWIDTH/DOWN-1:0]   out_data,
  output logic                     out_last,
  output logic                     out_valid,
  input  logic                     out_ready
);

  localparam int DWIDTH_OUT = DWIDTH / DOWN;

  logic [DOWN-1:0][DWIDTH_OUT-1:0] data_reg;
  logic                            valid_reg;
  logic                            last_reg;
  logic [$clog2(DOWN)-1:0]         counter;
  logic                            read_final;
  logic                            rollover;

  assign read_final = counter == $clog2(DOWN)'(DOWN - 1);
  assign rollover = read_final & out_ready;

  // a new wide word is taken once the final slice leaves
  // or at any time while the output holds nothing, so ready never waits on valid
  assign in_ready = rollover | ~out_valid;

  assign out_data = data_reg[counter];
  assign out_valid = valid_reg;
  // last belongs only to the final slice of a wide word
  assign out_last = last_reg & read_final;

  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
      valid_reg <= 1'b0;
      last_reg <= 1'b0;
    end else begin
      if (in_ready) begin
        valid_reg <= in_valid;
        last_reg <= in_last;
      end
      if (out_valid && out_ready) begin
        if (read_final) begin
          counter <= '0;
        end else begin
          counter <= counter + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_ready) begin
      data_reg <= in_data;
    end
  end

endmodule

// packs UP narrow input beats into one wide beat, first beat in the lowest lane
module axis_upsizer #(
  parameter int DWIDTH = 48,
  parameter int UP = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [DWIDTH-1:0]     in_data,
  input  logic                  in_last,
  input  logic                  in_valid,
  output logic                  in_ready,
  output logic [DWIDTH*UP-1:0]  out_data,
  output logic                  out_last,
  output logic                  out_valid,
  input  logic                  out_ready
);

  logic [UP-1:0][DWIDTH-1:0] data_reg;
  logic [$clog2(UP)-1:0]     counter;
  logic                      in_ok;
  logic                      write_final;

  assign in_ok = in_valid & in_ready;

  // the wide word closes when every lane is filled or when last arrives early
  // lanes above a short final group still carry the previous group's samples
  assign write_final = ((counter == $clog2(UP)'(UP - 1)) | in_last) & in_ok;

  // keep accepting while the output is empty or being taken this cycle
  assign in_ready = out_ready | ~out_valid;
  assign out_data = data_reg;

  always_ff @(posedge clk) begin
    if (reset) begin
      counter <= '0;
      data_reg <= '0;
      out_valid <= 1'b0;
      out_last <= 1'b0;
    end else begin
      if (in_ready) begin
        out_valid <= write_final;
        out_last <= in_last;
      end
      if (in_ok) begin
        data_reg[counter] <= in_data;
        if (write_final) begin
          counter <= '0;
        end else begin
          counter <= counter + 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/capture_writer.sv
`timescale 1ns/1ps
`default_nettype none

// stores one channel's word stream at consecutive offsets of that channel's region
// each word asks the arbiter for the memory port and is written in the granted cycle
module capture_writer
  import stream_pkg::*;
  import memory_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  channel_t    channel,
  input  logic        arm,
  input  word_beat_t  word,
  input  logic        word_valid,
  output logic        word_ready,
  output logic        req_valid,
  output mem_req_t    req,
  input  logic        grant,
  output logic        capture_done,
  output word_count_t word_count
);

  logic armed;
  logic room_left;
  logic transfer;

  // the count doubles as the offset of the next word, so a full region stops requests
  assign room_left = word_count < word_count_t'(REGION_WORDS);

  // only a word that is really there may ask for the port
  assign req_valid = armed & ~capture_done & room_left & word_valid;

  // back-pressure comes straight from the arbiter
  assign word_ready = grant;
  assign transfer = word_valid & word_ready;

  always_comb begin
    req.write = 1'b1;
    req.addr.region = channel;
    req.addr.offset = word_count[OFFSET_WIDTH-1:0];
    req.wdata = word.data;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      armed <= 1'b0;
      capture_done <= 1'b0;
      word_count <= '0;
    end else if (arm) begin
      // arm wins over a transfer in the same cycle and restarts at offset 0
      armed <= 1'b1;
      capture_done <= 1'b0;
      word_count <= '0;
    end else if (transfer) begin
      word_count <= word_count + 1'b1;
      // the last word ends the capture until the next arm pulse
      if (word.last) begin
        armed <= 1'b0;
        capture_done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: design/memory_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

// round robin arbiter for the single sample memory port
// the grant is combinational so a granted requester is served in the same cycle
module memory_arbiter
  import memory_pkg::*;
(
  input  logic                                clk,
  input  logic                                reset,
  input  logic [NUM_REQUESTERS-1:0]           req_valid,
  input  mem_req_t [NUM_REQUESTERS-1:0]       req,
  output logic [NUM_REQUESTERS-1:0]           grant,
  output logic                                mem_en,
  output mem_req_t                            mem_req
);

  // slot granted most recently, which gets the lowest priority next time
  logic [$clog2(NUM_REQUESTERS)-1:0] last_ptr;
  logic [$clog2(NUM_REQUESTERS)-1:0] grant_idx;

  // scan from the slot after last_ptr and wrap around, first requester wins
  always_comb begin
    int slot;
    grant = '0;
    grant_idx = last_ptr;
    for (int i = 1; i <= NUM_REQUESTERS; i++) begin
      slot = int'(last_ptr) + i;
      if (slot >= NUM_REQUESTERS) begin
        slot = slot - NUM_REQUESTERS;
      end
      if (req_valid[slot] && grant == '0) begin
        grant[slot] = 1'b1;
        grant_idx = slot[$clog2(NUM_REQUESTERS)-1:0];
      end
    end
  end

  assign mem_en = |grant;
  // the request contents only matter while mem_en is high
  assign mem_req = req[grant_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      // start as if the top slot went last so slot 0 comes first
      last_ptr <= $clog2(NUM_REQUESTERS)'(NUM_REQUESTERS - 1);
    end else if (mem_en) begin
      last_ptr <= grant_idx;
    end
  end

endmodule

`default_nettype wire

// File: design/sample_memory.sv
`timescale 1ns/1ps
`default_nettype none

// single port storage for both capture regions
// a granted read returns its word on the following cycle
module sample_memory
  import stream_pkg::*;
  import memory_pkg::*;
(
  input  logic                  clk,
  input  logic                  mem_en,
  input  mem_req_t              mem_req,
  output logic [WORD_WIDTH-1:0] rdata
);

  logic [WORD_WIDTH-1:0] storage [2**MEM_ADDR_WIDTH];

  // rdata keeps its value through writes and idle cycles
  always_ff @(posedge clk) begin
    if (mem_en) begin
      if (mem_req.write) begin
        storage[mem_req.addr] <= mem_req.wdata;
      end else begin
        rdata <= storage[mem_req.addr];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/readout_engine.sv
`timescale 1ns/1ps
`default_nettype none

// reads a run of words from one channel region and streams them out
// only one read is in flight at a time and the output is a single register
module readout_engine
  import stream_pkg::*;
  import memory_pkg::*;
(
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  read_start,
  input  channel_t              read_channel,
  input  word_count_t           read_count,
  output logic                  req_valid,
  output mem_req_t              req,
  input  logic                  grant,
  input  logic [WORD_WIDTH-1:0] rdata,
  output word_beat_t            out_beat,
  output logic                  out_valid,
  input  logic                  out_ready,
  output logic                  read_busy
);

  channel_t    channel_r;
  word_count_t count_r;
  // index of the next word to read from the region
  word_count_t issue_idx;
  // a read was granted last cycle and its data is on rdata now
  logic        pending;
  logic        pending_last;
  logic        issue;

  // a read goes out only when its data will find the output register free
  assign req_valid = read_busy & (issue_idx < count_r) & ~pending & (~out_valid | out_ready);
  assign issue = req_valid & grant;

  always_comb begin
    req.write = 1'b0;
    req.addr.region = channel_r;
    req.addr.offset = issue_idx[OFFSET_WIDTH-1:0];
    req.wdata = '0;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      read_busy <= 1'b0;
      pending <= 1'b0;
      out_valid <= 1'b0;
      issue_idx <= '0;
    end else begin
      // a start pulse while busy, or with nothing to read, does nothing
      if (read_start && !read_busy && read_count != '0) begin
        read_busy <= 1'b1;
        issue_idx <= '0;
      end else if (issue) begin
        issue_idx <= issue_idx + 1'b1;
      end
      pending <= issue;
      if (pending) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
      // the run ends once the beat carrying last has been taken
      if (out_valid && out_ready && out_beat.last) begin
        read_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (read_start && !read_busy) begin
      channel_r <= read_channel;
      count_r <= read_count;
    end
    if (issue) begin
      pending_last <= issue_idx == count_r - word_count_t'(1);
    end
    if (pending) begin
      out_beat.data <= rdata;
      out_beat.last <= pending_last;
    end
  end

endmodule

`default_nettype wire

// File: design/capture_top.sv
`timescale 1ns/1ps
`default_nettype none

// two channel capture buffer
// each channel packs 48 bit samples into 64 bit words and writes them to its
// own region while the readout engine streams words back out of either region
// all three share the one memory port through the round robin arbiter
module capture_top
  import stream_pkg::*;
  import memory_pkg::*;
(
  input  logic                           clk,
  input  logic                           reset,
  input  sample_beat_t [CHANNELS-1:0]    in_beat,
  input  logic [CHANNELS-1:0]            in_valid,
  output logic [CHANNELS-1:0]            in_ready,
  input  logic [CHANNELS-1:0]            arm,
  output logic [CHANNELS-1:0]            capture_done,
  output word_count_t [CHANNELS-1:0]     word_count,
  input  logic                           read_start,
  input  channel_t                       read_channel,
  input  word_count_t                    read_count,
  output word_beat_t                     out_beat,
  output logic                           out_valid,
  input  logic                           out_ready,
  output logic                           read_busy
);

  // converter outputs heading to the writers
  word_beat_t [CHANNELS-1:0]       conv_beat;
  logic [CHANNELS-1:0]             conv_valid;
  logic [CHANNELS-1:0]             conv_ready;

  // one request slot per writer plus the readout slot
  logic [NUM_REQUESTERS-1:0]       req_valid;
  mem_req_t [NUM_REQUESTERS-1:0]   req;
  logic [NUM_REQUESTERS-1:0]       grant;

  logic                            mem_en;
  mem_req_t                        mem_req;
  logic [WORD_WIDTH-1:0]           rdata;

  for (genvar ch = 0; ch < CHANNELS; ch++) begin : g_channel
    axis_width_converter #(
      .DWIDTH_IN(SAMPLE_WIDTH),
      .DWIDTH_OUT(WORD_WIDTH)
    ) conv_i (
      .clk,
      .reset,
      .in_data(in_beat[ch].data),
      .in_last(in_beat[ch].last),
      .in_valid(in_valid[ch]),
      .in_ready(in_ready[ch]),
      .out_data(conv_beat[ch].data),
      .out_last(conv_beat[ch].last),
      .out_valid(conv_valid[ch]),
      .out_ready(conv_ready[ch])
    );

    // the region a writer fills is fixed by the channel number wired here
    capture_writer writer_i (
      .clk,
      .reset,
      .channel(channel_t'(ch)),
      .arm(arm[ch]),
      .word(conv_beat[ch]),
      .word_valid(conv_valid[ch]),
      .word_ready(conv_ready[ch]),
      .req_valid(req_valid[SLOT_WRITER0 + ch]),
      .req(req[SLOT_WRITER0 + ch]),
      .grant(grant[SLOT_WRITER0 + ch]),
      .capture_done(capture_done[ch]),
      .word_count(word_count[ch])
    );
  end

  memory_arbiter arbiter_i (
    .clk,
    .reset,
    .req_valid,
    .req,
    .grant,
    .mem_en,
    .mem_req
  );

  sample_memory memory_i (
    .clk,
    .mem_en,
    .mem_req,
    .rdata
  );

  readout_engine readout_i (
    .clk,
    .reset,
    .read_start,
    .read_channel,
    .read_count,
    .req_valid(req_valid[SLOT_READOUT]),
    .req(req[SLOT_READOUT]),
    .grant(grant[SLOT_READOUT]),
    .rdata,
    .out_beat,
    .out_valid,
    .out_ready,
    .read_busy
  );

endmodule

`default_nettype wire

// File: testbench/capture_assertions.sv
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the shared memory port and on the readout stream
module capture_assertions
  import stream_pkg::*;
  import memory_pkg::*;
(
  input logic                      clk,
  input logic                      reset,
  input logic [NUM_REQUESTERS-1:0] req_valid,
  input logic [NUM_REQUESTERS-1:0] grant,
  input word_beat_t                out_beat,
  input logic                      out_valid,
  input logic                      out_ready,
  input logic [CHANNELS-1:0]       capture_done
);

  // number of assertion failures seen so far
  int failures = 0;

  // at most one requester owns the memory port in any cycle
  grant_one_hot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
    else begin
      $error("more than one memory grant in one cycle");
      failures++;
    end

  // the arbiter never hands the port to an idle slot
  grant_requested: assert property (@(posedge clk) disable iff (reset)
    (grant & ~req_valid) == '0)
    else begin
      $error("memory grant given to a slot that is not requesting");
      failures++;
    end

  // a stalled readout beat must hold its value and stay valid
  out_beat_stable: assert property (@(posedge clk) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else begin
      $error("readout beat changed while stalled");
      failures++;
    end

  // the first cycle out of reset starts with nothing captured and nothing to send
  reset_outputs_low: assert property (@(posedge clk)
    $fell(reset) |-> !out_valid && capture_done == '0)
    else begin
      $error("out_valid or capture_done high right after reset");
      failures++;
    end

endmodule

bind capture_top capture_assertions assertions_i (
  .clk(clk),
  .reset(reset),
  .req_valid(req_valid),
  .grant(grant),
  .out_beat(out_beat),
  .out_valid(out_valid),
  .out_ready(out_ready),
  .capture_done(capture_done)
);

`default_nettype wire

// File: testbench/capture_tb.sv
`timescale 1ns/1ps
`default_nettype none

// directed testbench for the two channel capture buffer
module capture_tb
  import stream_pkg::*;
  import memory_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int WAIT_LIMIT = 200;

  logic                        clk;
  logic                        reset;
  sample_beat_t [CHANNELS-1:0] in_beat;
  logic [CHANNELS-1:0]         in_valid;
  logic [CHANNELS-1:0]         in_ready;
  logic [CHANNELS-1:0]         arm;
  logic [CHANNELS-1:0]         capture_done;
  word_count_t [CHANNELS-1:0]  word_count;
  logic                        read_start;
  channel_t                    read_channel;
  word_count_t                 read_count;
  word_beat_t                  out_beat;
  logic                        out_valid;
  logic                        out_ready;
  logic                        read_busy;

  // 16 bit galois register, one step per random bit
  logic [15:0] lfsr_state;

  // samples prepared for the next burst of each channel
  logic [SAMPLE_WIDTH-1:0] burst [CHANNELS][16];

  // reference model: upsizer lanes, next lane, region contents and words written
  logic [SAMPLE_WIDTH-1:0] lanes [CHANNELS][4];
  int                      lane_idx [CHANNELS];
  logic [WORD_WIDTH-1:0]   region_data [CHANNELS][REGION_WORDS];
  int                      model_count [CHANNELS];

  string test_name;
  int    tests;
  int    checks;
  int    errors;
  int    errors_before;

  capture_top uut (
    .clk,
    .reset,
    .in_beat,
    .in_valid,
    .in_ready,
    .arm,
    .capture_done,
    .word_count,
    .read_start,
    .read_channel,
    .read_count,
    .out_beat,
    .out_valid,
    .out_ready,
    .read_busy
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // taps of x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output logic [63:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits[i] = lfsr_state[0];
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic compare_word(input string what, input word_beat_t expected,
                              input word_beat_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s %s: expected %h last %b, actual %h last %b", test_name, what,
               expected.data, expected.last, actual.data, actual.last);
    end
  endtask

  task automatic compare_count(input string what, input word_count_t expected,
                               input word_count_t actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s %s: expected %0d, actual %0d", test_name, what, expected, actual);
    end
  endtask

  task automatic compare_flag(input string what, input logic expected, input logic actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %s %s: expected %b, actual %b", test_name, what, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("%s: gave up waiting for %s", test_name, what);
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_before = errors;
    tests++;
  endtask

  task automatic end_test();
    if (errors == errors_before) begin
      $display("%s: ok", test_name);
    end else begin
      $display("%s: %0d errors", test_name, errors - errors_before);
    end
  endtask

  // 4 lanes close a group, so does last, and unwritten lanes keep older samples
  task automatic model_sample(input int ch, input logic [SAMPLE_WIDTH-1:0] sample,
                              input logic last);
    logic [4*SAMPLE_WIDTH-1:0] wide;
    lanes[ch][lane_idx[ch]] = sample;
    if (lane_idx[ch] == 3 || last) begin
      wide = {lanes[ch][3], lanes[ch][2], lanes[ch][1], lanes[ch][0]};
      // the wide word leaves as three memory words, lowest bits first
      for (int k = 0; k < 3; k++) begin
        region_data[ch][model_count[ch]] = wide[WORD_WIDTH*k +: WORD_WIDTH];
        model_count[ch]++;
      end
      lane_idx[ch] = 0;
    end else begin
      lane_idx[ch]++;
    end
  endtask

  task automatic fill_burst(input int ch, input int n);
    logic [63:0] bits;
    for (int i = 0; i < n; i++) begin
      take_bits(SAMPLE_WIDTH, bits);
      burst[ch][i] = bits[SAMPLE_WIDTH-1:0];
    end
  endtask

  task automatic arm_channel(input int ch);
    @(negedge clk);
    arm[ch] = 1'b1;
    @(negedge clk);
    arm[ch] = 1'b0;
    model_count[ch] = 0;
  endtask

  // last goes with the final sample, each one held until in_ready takes it
  task automatic send_burst(input int ch, input int n);
    sample_beat_t beat;
    int           waited;
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      beat.data = burst[ch][i];
      beat.last = (i == n - 1);
      in_beat[ch] = beat;
      in_valid[ch] = 1'b1;
      // in_ready settles once the new inputs have propagated
      #1;
      waited = 0;
      while (!in_ready[ch] && waited < WAIT_LIMIT) begin
        @(negedge clk);
        #1;
        waited++;
      end
      if (!in_ready[ch]) begin
        report_timeout($sformatf("in_ready on channel %0d", ch));
        break;
      end
      model_sample(ch, beat.data, beat.last);
    end
    @(negedge clk);
    in_valid[ch] = 1'b0;
    in_beat[ch] = '0;
  endtask

  task automatic wait_done(input int ch);
    int waited;
    waited = 0;
    while (!capture_done[ch] && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!capture_done[ch]) begin
      report_timeout($sformatf("capture_done on channel %0d", ch));
    end
  endtask

  // reads count words of a region, with optional random stalls and a start pulse mid run
  task automatic readout(input int ch, input int count, input bit stall, input bit poke);
    word_beat_t  expected;
    logic [63:0] bits;
    int          idx;
    int          waited;
    bit          poked;
    idx = 0;
    waited = 0;
    poked = 1'b0;
    @(negedge clk);
    read_channel = channel_t'(ch);
    read_count = word_count_t'(count);
    read_start = 1'b1;
    @(negedge clk);
    while (idx < count && waited < WAIT_LIMIT) begin
      read_start = 1'b0;
      if (poke && !poked && idx == 2) begin
        // a start for the other region while busy, the engine has to ignore it
        read_channel = channel_t'(1 - ch);
        read_count = word_count_t'(1);
        read_start = 1'b1;
        poked = 1'b1;
      end
      out_ready = 1'b1;
      if (stall) begin
        take_bits(1, bits);
        out_ready = bits[0];
      end
      if (out_valid && out_ready) begin
        expected.data = region_data[ch][idx];
        expected.last = (idx == count - 1);
        compare_word($sformatf("channel %0d word %0d", ch, idx), expected, out_beat);
        idx++;
        waited = 0;
      end else begin
        waited++;
      end
      @(negedge clk);
    end
    read_start = 1'b0;
    out_ready = 1'b0;
    if (idx < count) begin
      report_timeout($sformatf("readout word %0d of channel %0d", idx, ch));
    end
    waited = 0;
    while (read_busy && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (read_busy) begin
      report_timeout("read_busy to drop");
    end
    compare_flag("out_valid after the run", 1'b0, out_valid);
  endtask

  task automatic check_reset_state();
    begin_test("reset state");
    for (int ch = 0; ch < CHANNELS; ch++) begin
      compare_flag($sformatf("capture_done %0d", ch), 1'b0, capture_done[ch]);
      compare_count($sformatf("word_count %0d", ch), '0, word_count[ch]);
    end
    compare_flag("out_valid", 1'b0, out_valid);
    compare_flag("read_busy", 1'b0, read_busy);
    end_test();
  endtask

  task automatic single_channel_round_trip();
    begin_test("single channel");
    arm_channel(0);
    fill_burst(0, 8);
    send_burst(0, 8);
    wait_done(0);
    compare_flag("capture_done", 1'b1, capture_done[0]);
    compare_count("word_count", word_count_t'(model_count[0]), word_count[0]);
    readout(0, model_count[0], 1'b0, 1'b0);
    end_test();
  endtask

  // both writers compete for the memory port while their bursts arrive together
  task automatic concurrent_channels();
    begin_test("concurrent channels");
    arm_channel(0);
    arm_channel(1);
    fill_burst(0, 8);
    fill_burst(1, 12);
    fork
      send_burst(0, 8);
      send_burst(1, 12);
    join
    wait_done(0);
    wait_done(1);
    compare_count("word_count 0", word_count_t'(model_count[0]), word_count[0]);
    compare_count("word_count 1", word_count_t'(model_count[1]), word_count[1]);
    readout(0, model_count[0], 1'b0, 1'b0);
    readout(1, model_count[1], 1'b0, 1'b0);
    end_test();
  endtask

  // the second group holds two samples, its upper lanes come from the first group
  task automatic partial_group();
    begin_test("partial group");
    arm_channel(1);
    fill_burst(1, 6);
    send_burst(1, 6);
    wait_done(1);
    compare_count("word_count", word_count_t'(model_count[1]), word_count[1]);
    readout(1, model_count[1], 1'b0, 1'b0);
    end_test();
  endtask

  task automatic readout_backpressure();
    begin_test("readout back-pressure");
    readout(0, model_count[0], 1'b1, 1'b1);
    end_test();
  endtask

  // three new words land at offsets 0 to 2 and the older words above stay in place
  task automatic rearm_overwrite();
    begin_test("re-arm");
    arm_channel(0);
    compare_flag("capture_done after arm", 1'b0, capture_done[0]);
    compare_count("word_count after arm", '0, word_count[0]);
    fill_burst(0, 4);
    send_burst(0, 4);
    wait_done(0);
    compare_flag("capture_done", 1'b1, capture_done[0]);
    compare_count("word_count", word_count_t'(model_count[0]), word_count[0]);
    readout(0, 6, 1'b0, 1'b0);
    end_test();
  endtask

  initial begin
    lfsr_state = 16'd25731;
    tests = 0;
    checks = 0;
    errors = 0;
    reset = 1'b1;
    in_beat = '0;
    in_valid = '0;
    arm = '0;
    read_start = 1'b0;
    read_channel = '0;
    read_count = '0;
    out_ready = 1'b0;
    // the upsizer lanes start out cleared
    for (int ch = 0; ch < CHANNELS; ch++) begin
      lane_idx[ch] = 0;
      model_count[ch] = 0;
      for (int k = 0; k < 4; k++) begin
        lanes[ch][k] = '0;
      end
    end
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    check_reset_state();
    single_channel_round_trip();
    concurrent_channels();
    partial_group();
    readout_backpressure();
    rearm_overwrite();

    // failures of the bound protocol checks count as errors as well
    errors += uut.assertions_i.failures;

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
design/stream_pkg.sv
design/memory_pkg.sv
design/axis_width_converter.sv
design/capture_writer.sv
design/memory_arbiter.sv
design/sample_memory.sv
design/readout_engine.sv
design/capture_top.sv
testbench/capture_assertions.sv
testbench/capture_tb.sv

// File: Makefile
# Verilator build and run of the capture buffer testbench

SOURCES := $(shell cat filelist.f)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/capture_tb: filelist.f $(SOURCES)
	verilator --binary --assert -j 0 --top-module capture_tb -f filelist.f -o capture_tb

# the run passes only when the pass line shows up in the output
run: obj_dir/capture_tb
	@out="$$(./obj_dir/capture_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf obj_dir
